/* frontend.f */
rv_isa_pkg.sv
fetch_pkg.sv
instr_scan.sv
branch_history.sv
pc_gen.sv
wb_fetch.sv
fetch_queue.sv
frontend.sv
frontend_assertions.sv
tb_frontend.sv

/* Bender.yml */
package:
  name: frontend

sources:
  - rv_isa_pkg.sv
  - fetch_pkg.sv
  - instr_scan.sv
  - branch_history.sv
  - pc_gen.sv
  - wb_fetch.sv
  - fetch_queue.sv
  - frontend.sv
  - target: simulation
    files:
      - frontend_assertions.sv
      - tb_frontend.sv

/* tb_frontend.sv */
// frontend testbench with clock, reset, Wishbone memory slave, reference model and checks
`timescale 1ns/1ps

module tb_frontend;

    localparam logic [31:0] BOOT_ADDR   = 32'h0000_1000;
    localparam int          BHT_ENTRIES = 64;
    localparam int          NUM_XFERS   = 400;
    // each transfer gets 5 bus cycles and 10 stall cycles
    localparam int          CYCLE_LIMIT = NUM_XFERS * (5 + 10);
    localparam int          KIND_ALU    = 0;
    localparam int          KIND_BRANCH = 1;
    localparam int          KIND_JAL    = 2;

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic        resolve_valid_i, resolve_branch_i, resolve_taken_i, resolve_mispredict_i;
    logic [31:0] resolve_pc_i, resolve_target_i;
    logic        eret_i, trap_i;
    logic [31:0] epc_i, trap_vector_i;
    logic        wb_cyc_o, wb_stb_o, wb_ack_i;
    logic [31:0] wb_adr_o, wb_dat_i;
    logic        fetch_valid_o, fetch_taken_o, fetch_ready_i;
    logic [31:0] fetch_instr_o, fetch_pc_o;

    int          seed = 80;
    logic [31:0] mem_key0, mem_key1;
    // model state: next expected pc and the counter table
    logic [31:0] model_pc;
    logic        model_valid [BHT_ENTRIES];
    logic [1:0]  model_cnt   [BHT_ENTRIES];
    // bus slave state
    logic        bus_busy;
    int          bus_wait;
    int          xfer_cnt = 0;
    int          cycle_cnt = 0;
    int          pc_err = 0;
    int          instr_err = 0;
    int          taken_err = 0;
    int          other_err = 0;

    always #2 clk_i = ~clk_i;

    frontend uut (.*);

    bind frontend frontend_assertions i_assertions (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .wb_cyc_i(wb_cyc_o), .wb_stb_i(wb_stb_o), .wb_adr_i(wb_adr_o), .wb_ack_i(wb_ack_i),
        .redirect_i(redirect),
        .fetch_valid_i(fetch_valid_o), .fetch_ready_i(fetch_ready_i),
        .fetch_instr_i(fetch_instr_o), .fetch_pc_i(fetch_pc_o), .fetch_taken_i(fetch_taken_o)
    );

    // ------------------------------------------------------------
    // sparse memory, every word hashed from its full address
    // ------------------------------------------------------------
    function automatic logic [31:0] mix(input logic [31:0] x);
        logic [31:0] h;
        h = x ^ (x >> 16);
        h = h * 32'h7feb352d;
        h = h ^ (h >> 15);
        h = h * 32'h846ca68b;
        return h ^ (h >> 16);
    endfunction

    // word at addr with its class and offset, as generated
    task automatic gen_instr(input logic [31:0] addr, output logic [31:0] word,
                             output int kind, output logic [31:0] off);
        logic [31:0] h1, h2, mag;
        h1 = mix(addr ^ mem_key0);
        h2 = mix(addr ^ mem_key1);
        off = '0;
        if (h1[2:0] < 3'd2) begin
            // branch, 4 to 64 bytes either way
            kind = KIND_BRANCH;
            mag  = 32'(h1[6:3] + 1) * 4;
            off  = h1[7] ? 32'd0 - mag : mag;
            word = {off[12], off[10:5], h2[24:15], h2[14], 1'b0, h2[12],
                    off[4:1], off[11], 7'b1100011};
        end else if (h1[2:0] == 3'd2) begin
            kind = KIND_JAL;
            mag  = 32'(h1[8:3] + 1) * 4;
            off  = h1[9] ? 32'd0 - mag : mag;
            word = {off[20], off[10:1], off[11], off[19:12], h2[11:7], 7'b1101111};
        end else begin
            // op-imm, never redirects fetch
            kind = KIND_ALU;
            word = {h2[31:7], 7'b0010011};
        end
    endtask

    function automatic logic predict(input logic [31:0] pc, input int kind,
                                     input logic [31:0] off);
        int idx;
        idx = (pc >> 2) % BHT_ENTRIES;
        if (kind == KIND_JAL) begin
            return 1'b1;
        end
        if (kind != KIND_BRANCH) begin
            return 1'b0;
        end
        // valid entry wins, else backward taken
        return model_valid[idx] ? model_cnt[idx][1] : off[31];
    endfunction

    task automatic train_counter(input logic [31:0] pc, input logic taken);
        int         idx;
        logic [1:0] cnt;
        idx = (pc >> 2) % BHT_ENTRIES;
        // fresh entry starts weakly not taken
        cnt = model_valid[idx] ? model_cnt[idx] : 2'd1;
        if (taken && cnt != 2'd3) begin
            cnt = cnt + 2'd1;
        end else if (!taken && cnt != 2'd0) begin
            cnt = cnt - 2'd1;
        end
        model_valid[idx] = 1'b1;
        model_cnt[idx]   = cnt;
    endtask

    // ------------------------------------------------------------
    // checks and model update at the rising edge
    // ------------------------------------------------------------
    task automatic check_transfer();
        logic [31:0] exp_word, off;
        int          kind;
        logic        exp_taken;
        gen_instr(model_pc, exp_word, kind, off);
        exp_taken = predict(model_pc, kind, off);
        assert (fetch_pc_o == model_pc) else begin
            pc_err++;
            $display("MISMATCH fetch_pc_o: got %h expected %h", fetch_pc_o, model_pc);
        end
        assert (fetch_instr_o == exp_word) else begin
            instr_err++;
            $display("MISMATCH fetch_instr_o: got %h expected %h", fetch_instr_o, exp_word);
        end
        assert (fetch_taken_o == exp_taken) else begin
            taken_err++;
            $display("MISMATCH fetch_taken_o: got %h expected %h", fetch_taken_o, exp_taken);
        end
        model_pc = exp_taken ? model_pc + off : model_pc + 32'd4;
        xfer_cnt++;
    endtask

    // table first, then the highest redirect
    task automatic apply_redirect();
        if (resolve_valid_i && resolve_branch_i) begin
            train_counter(resolve_pc_i, resolve_taken_i);
        end
        if (trap_i) begin
            model_pc = trap_vector_i;
        end else if (eret_i) begin
            model_pc = epc_i;
        end else if (resolve_valid_i && resolve_mispredict_i) begin
            model_pc = resolve_target_i;
        end
    endtask

    // ------------------------------------------------------------
    // stimulus at the falling edge
    // ------------------------------------------------------------
    function automatic logic [31:0] pick_pc(input int span);
        return BOOT_ADDR + 32'(({$random(seed)} % span) * 4);
    endfunction

    // slave with 0 to 3 wait cycles per request
    task automatic drive_bus();
        logic [31:0] word, off;
        int          kind;
        if (wb_ack_i) begin
            wb_ack_i = 1'b0;
            bus_busy = 1'b0;
        end
        if (wb_cyc_o && wb_stb_o && !bus_busy) begin
            bus_busy = 1'b1;
            bus_wait = {$random(seed)} % 4;
        end
        if (bus_busy && bus_wait == 0) begin
            gen_instr(wb_adr_o, word, kind, off);
            wb_dat_i = word;
            wb_ack_i = 1'b1;
        end else if (bus_busy) begin
            bus_wait--;
        end
    endtask

    task automatic drive_backend();
        int kind;
        fetch_ready_i        = ({$random(seed)} % 10) < 7;
        resolve_valid_i      = 1'b0;
        resolve_branch_i     = 1'b0;
        resolve_mispredict_i = 1'b0;
        eret_i               = 1'b0;
        trap_i               = 1'b0;
        resolve_pc_i         = pick_pc(16);
        resolve_taken_i      = 1'($random(seed));
        resolve_target_i     = pick_pc(64);
        epc_i                = pick_pc(64);
        trap_vector_i        = pick_pc(64);
        if ({$random(seed)} % 16 == 0) begin
            kind = {$random(seed)} % 5;
            case (kind)
                // branch resolve always rides with a trap
                0, 1: begin
                    resolve_valid_i      = 1'b1;
                    resolve_branch_i     = 1'b1;
                    resolve_mispredict_i = 1'($random(seed));
                    trap_i               = 1'b1;
                    if (kind == 0) begin
                        trap_vector_i = resolve_pc_i;
                    end
                end
                2: eret_i = 1'b1;
                3: begin
                    resolve_valid_i      = 1'b1;
                    resolve_mispredict_i = 1'b1;
                end
                default: begin
                    resolve_valid_i      = 1'b1;
                    resolve_mispredict_i = 1'b1;
                    eret_i               = 1'b1;
                    trap_i               = 1'($random(seed));
                end
            endcase
        end
    endtask

    initial begin
        int total;
        mem_key0 = $random(seed);
        mem_key1 = $random(seed);
        for (int i = 0; i < BHT_ENTRIES; i++) begin
            model_valid[i] = 1'b0;
            model_cnt[i]   = 2'd0;
        end
        {resolve_valid_i, resolve_branch_i, resolve_taken_i, resolve_mispredict_i} = '0;
        {resolve_pc_i, resolve_target_i, epc_i, trap_vector_i} = '0;
        {eret_i, trap_i, wb_ack_i, fetch_ready_i, bus_busy} = '0;
        wb_dat_i = '0;
        bus_wait = 0;
        rst_ni   = 1'b0;
        repeat (10) @(posedge clk_i);
        assert (!wb_cyc_o && !fetch_valid_o) else begin
            other_err++;
            $display("bus cycle or fetch valid active during reset");
        end
        @(negedge clk_i);
        rst_ni   = 1'b1;
        model_pc = BOOT_ADDR;
        drive_bus();
        drive_backend();
        while (xfer_cnt < NUM_XFERS && cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk_i);
            cycle_cnt++;
            if (fetch_valid_o && fetch_ready_i) begin
                check_transfer();
            end
            apply_redirect();
            @(negedge clk_i);
            drive_bus();
            drive_backend();
        end
        assert (xfer_cnt == NUM_XFERS) else begin
            other_err++;
            $display("timeout after %0d cycles with %0d of %0d transfers done",
                     cycle_cnt, xfer_cnt, NUM_XFERS);
        end
        total = pc_err + instr_err + taken_err + other_err + uut.i_assertions.fail_cnt;
        $display("errors: pc %0d, instr %0d, taken %0d, other %0d, assertion %0d",
                 pc_err, instr_err, taken_err, other_err, uut.i_assertions.fail_cnt);
        if (total == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* frontend_assertions.sv */
// concurrent checks on the Wishbone request and the back-end fetch handshake
`timescale 1ns/1ps

module frontend_assertions import rv_isa_pkg::*; import fetch_pkg::*; (
    input logic               clk_i,
    input logic               rst_ni,
    // Wishbone side
    input logic               wb_cyc_i,
    input logic               wb_stb_i,
    input logic [XLEN-1:0]    wb_adr_i,
    input logic               wb_ack_i,
    // any redirect empties the queue
    input logic               redirect_i,
    // back-end side
    input logic               fetch_valid_i,
    input logic               fetch_ready_i,
    input logic [INSTR_W-1:0] fetch_instr_i,
    input logic [XLEN-1:0]    fetch_pc_i,
    input logic               fetch_taken_i
);

    // failures seen so far, read by the testbench at the end
    int unsigned fail_cnt = 0;

    // a strobe only inside a cycle
    stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_stb_i |-> wb_cyc_i)
    else begin
        fail_cnt++;
        $error("wb_stb_o high while wb_cyc_o is low");
    end

    // request and address held until the slave acks
    adr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (wb_stb_i && !wb_ack_i) |=> (wb_stb_i && $stable(wb_adr_i)))
    else begin
        fail_cnt++;
        $error("wb request dropped or address changed before ack");
    end

    // stalled entry holds unless a redirect flushes it
    fetch_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (fetch_valid_i && !fetch_ready_i && !redirect_i) |=>
        (fetch_valid_i && $stable(fetch_instr_i) && $stable(fetch_pc_i)
         && $stable(fetch_taken_i)))
    else begin
        fail_cnt++;
        $error("fetch outputs changed while stalled by the back end");
    end

endmodule

/* frontend.sv */
// instruction fetch frontend top level, wires the fetch pipeline
`timescale 1ns/1ps

module frontend import rv_isa_pkg::*; import fetch_pkg::*; #(
    parameter logic [XLEN-1:0] BootAddr   = DEF_BOOT_ADDR,
    parameter int              BhtEntries = DEF_BHT_ENTRIES,
    parameter int              QueueDepth = DEF_QUEUE_DEPTH
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    // branch resolve from the back end
    input  logic               resolve_valid_i,
    input  logic [XLEN-1:0]    resolve_pc_i,
    input  logic               resolve_branch_i,
    input  logic               resolve_taken_i,
    input  logic               resolve_mispredict_i,
    input  logic [XLEN-1:0]    resolve_target_i,
    // exception return and trap
    input  logic               eret_i,
    input  logic [XLEN-1:0]    epc_i,
    input  logic               trap_i,
    input  logic [XLEN-1:0]    trap_vector_i,
    // Wishbone fetch bus
    output logic               wb_cyc_o,
    output logic               wb_stb_o,
    output logic [XLEN-1:0]    wb_adr_o,
    input  logic [INSTR_W-1:0] wb_dat_i,
    input  logic               wb_ack_i,
    // back-end fetch port
    output logic               fetch_valid_o,
    output logic [INSTR_W-1:0] fetch_instr_o,
    output logic [XLEN-1:0]    fetch_pc_o,
    output logic               fetch_taken_o,
    input  logic               fetch_ready_i
);

    logic [XLEN-1:0]    fetch_pc;
    logic               resp_valid;
    logic [INSTR_W-1:0] resp_instr;
    logic [XLEN-1:0]    resp_pc;
    logic               is_branch, is_jal;
    logic [XLEN-1:0]    offset;
    logic               hit_valid, hit_taken;
    logic               pred_taken, redirect, queue_full;

    // ------------------------------------------------------------
    // pc and prediction
    // ------------------------------------------------------------
    pc_gen #(.BootAddr(BootAddr)) i_pc_gen (
        .clk_i, .rst_ni,
        .resp_valid_i(resp_valid), .resp_pc_i(resp_pc),
        .is_branch_i(is_branch), .is_jal_i(is_jal), .offset_i(offset),
        .hit_valid_i(hit_valid), .hit_taken_i(hit_taken),
        .resolve_valid_i, .resolve_mispredict_i, .resolve_target_i,
        .eret_i, .epc_i, .trap_i, .trap_vector_i,
        .fetch_pc_o(fetch_pc), .pred_taken_o(pred_taken), .redirect_o(redirect)
    );

    // only resolved conditional branches train the table
    branch_history #(.BhtEntries(BhtEntries)) i_branch_history (
        .clk_i, .rst_ni,
        .lookup_pc_i(fetch_pc), .hit_valid_o(hit_valid), .hit_taken_o(hit_taken),
        .update_valid_i(resolve_valid_i & resolve_branch_i),
        .update_pc_i(resolve_pc_i), .update_taken_i(resolve_taken_i)
    );

    instr_scan i_instr_scan (
        .instr_i(resp_instr), .is_branch_o(is_branch), .is_jal_o(is_jal), .offset_o(offset)
    );

    // ------------------------------------------------------------
    // bus and queue
    // ------------------------------------------------------------
    wb_fetch i_wb_fetch (
        .clk_i, .rst_ni,
        .fetch_pc_i(fetch_pc), .queue_full_i(queue_full), .redirect_i(redirect),
        .wb_cyc_o, .wb_stb_o, .wb_adr_o, .wb_dat_i, .wb_ack_i,
        .resp_valid_o(resp_valid), .resp_instr_o(resp_instr), .resp_pc_o(resp_pc)
    );

    fetch_queue #(.QueueDepth(QueueDepth)) i_fetch_queue (
        .clk_i, .rst_ni, .flush_i(redirect),
        .push_i(resp_valid), .push_instr_i(resp_instr), .push_pc_i(resp_pc),
        .push_taken_i(pred_taken), .full_o(queue_full),
        .fetch_valid_o, .fetch_instr_o, .fetch_pc_o, .fetch_taken_o, .fetch_ready_i
    );

endmodule

/* fetch_queue.sv */
// circular fetch queue with valid/ready output and flush
`timescale 1ns/1ps

module fetch_queue import rv_isa_pkg::*; import fetch_pkg::*; #(
    parameter int QueueDepth = DEF_QUEUE_DEPTH
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               flush_i,
    // write side
    input  logic               push_i,
    input  logic [INSTR_W-1:0] push_instr_i,
    input  logic [XLEN-1:0]    push_pc_i,
    input  logic               push_taken_i,
    output logic               full_o,
    // back-end side
    output logic               fetch_valid_o,
    output logic [INSTR_W-1:0] fetch_instr_o,
    output logic [XLEN-1:0]    fetch_pc_o,
    output logic               fetch_taken_o,
    input  logic               fetch_ready_i
);

    localparam int PtrW = $clog2(QueueDepth);
    localparam int CntW = $clog2(QueueDepth + 1);

    logic [INSTR_W-1:0] instr_q [QueueDepth];
    logic [XLEN-1:0]    pc_q    [QueueDepth];
    logic               taken_q [QueueDepth];

    logic [PtrW-1:0] rd_ptr_q;
    logic [PtrW-1:0] wr_ptr_q;
    logic [CntW-1:0] count_q;
    logic            push;
    logic            pop;

    assign full_o        = (count_q == CntW'(QueueDepth));
    assign fetch_valid_o = (count_q != '0);
    assign fetch_instr_o = instr_q[rd_ptr_q];
    assign fetch_pc_o    = pc_q[rd_ptr_q];
    assign fetch_taken_o = taken_q[rd_ptr_q];

    // a flush swallows the push of the same cycle
    assign push = push_i & ~flush_i & ~full_o;
    assign pop  = fetch_valid_o & fetch_ready_i;

    // ------------------------------------------------------------
    // pointers and count
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PtrW'(QueueDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PtrW'(QueueDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CntW'(push) - CntW'(pop);
        end
    end

    // entry storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            instr_q[wr_ptr_q] <= push_instr_i;
            pc_q[wr_ptr_q]    <= push_pc_i;
            taken_q[wr_ptr_q] <= push_taken_i;
        end
    end

endmodule

/* wb_fetch.sv */
// Wishbone classic read master, one word per request, stale response drop
`timescale 1ns/1ps

module wb_fetch import rv_isa_pkg::*; import fetch_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_ni,
    // request side
    input  logic [XLEN-1:0]    fetch_pc_i,
    input  logic               queue_full_i,
    input  logic               redirect_i,
    // Wishbone master
    output logic               wb_cyc_o,
    output logic               wb_stb_o,
    output logic [XLEN-1:0]    wb_adr_o,
    input  logic [INSTR_W-1:0] wb_dat_i,
    input  logic               wb_ack_i,
    // response, one cycle per accepted word
    output logic               resp_valid_o,
    output logic [INSTR_W-1:0] resp_instr_o,
    output logic [XLEN-1:0]    resp_pc_o
);

    typedef enum logic {
        IDLE,
        BUSY
    } state_e;

    state_e          state_q;
    logic            stale_q;
    logic [XLEN-1:0] adr_q;
    logic            start;

    // no new request into a full queue or on a redirect cycle
    assign start = (state_q == IDLE) & ~queue_full_i & ~redirect_i;

    // ------------------------------------------------------------
    // bus outputs
    // ------------------------------------------------------------
    assign wb_cyc_o = (state_q == BUSY);
    assign wb_stb_o = (state_q == BUSY);
    assign wb_adr_o = adr_q;

    // redirect in the ack cycle also kills the word
    assign resp_valid_o = wb_cyc_o & wb_ack_i & ~stale_q & ~redirect_i;
    assign resp_instr_o = wb_dat_i;
    assign resp_pc_o    = adr_q;

    // ------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            stale_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    stale_q <= 1'b0;
                    if (start) begin
                        state_q <= BUSY;
                    end
                end
                BUSY: begin
                    if (wb_ack_i) begin
                        state_q <= IDLE;
                        stale_q <= 1'b0;
                    end else if (redirect_i) begin
                        // transfer runs out on the bus, answer is dropped
                        stale_q <= 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // address held until ack
    always_ff @(posedge clk_i) begin
        if (start) begin
            adr_q <= fetch_pc_i;
        end
    end

endmodule

/* pc_gen.sv */
// next-pc register with redirect precedence, prediction choice and boot load
`timescale 1ns/1ps

module pc_gen import rv_isa_pkg::*; import fetch_pkg::*; #(
    parameter logic [XLEN-1:0] BootAddr = DEF_BOOT_ADDR
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    // response under scan
    input  logic            resp_valid_i,
    input  logic [XLEN-1:0] resp_pc_i,
    input  logic            is_branch_i,
    input  logic            is_jal_i,
    input  logic [XLEN-1:0] offset_i,
    // table lookup for the response pc
    input  logic            hit_valid_i,
    input  logic            hit_taken_i,
    // back-end redirects
    input  logic            resolve_valid_i,
    input  logic            resolve_mispredict_i,
    input  logic [XLEN-1:0] resolve_target_i,
    input  logic            eret_i,
    input  logic [XLEN-1:0] epc_i,
    input  logic            trap_i,
    input  logic [XLEN-1:0] trap_vector_i,
    // to fetch
    output logic [XLEN-1:0] fetch_pc_o,
    output logic            pred_taken_o,
    output logic            redirect_o
);

    logic            boot_load_q;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_d;
    logic            mispredict;
    logic            taken;

    assign mispredict = resolve_valid_i & resolve_mispredict_i;
    assign redirect_o = mispredict | eret_i | trap_i;

    // ------------------------------------------------------------
    // prediction
    // ------------------------------------------------------------
    // jal always taken, branches use the table or fall back to
    // backward taken on a miss
    always_comb begin
        taken = 1'b0;
        if (is_jal_i) begin
            taken = 1'b1;
        end else if (is_branch_i) begin
            taken = hit_valid_i ? hit_taken_i : offset_i[XLEN-1];
        end
    end

    assign pred_taken_o = resp_valid_i & taken;

    // boot address shows up while the register is being loaded
    assign fetch_pc_o = boot_load_q ? BootAddr : pc_q;

    // ------------------------------------------------------------
    // next pc, lowest precedence first
    // ------------------------------------------------------------
    always_comb begin
        pc_d = fetch_pc_o;
        if (resp_valid_i) begin
            pc_d = taken ? resp_pc_i + offset_i : resp_pc_i + XLEN'(ILEN_BYTES);
        end
        if (mispredict) begin
            pc_d = resolve_target_i;
        end
        if (eret_i) begin
            pc_d = epc_i;
        end
        // trap wins over everything
        if (trap_i) begin
            pc_d = trap_vector_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            boot_load_q <= 1'b1;
            pc_q        <= '0;
        end else begin
            boot_load_q <= 1'b0;
            pc_q        <= pc_d;
        end
    end

endmodule

/* branch_history.sv */
// branch history table of two-bit saturating counters with valid bits
`timescale 1ns/1ps

module branch_history import fetch_pkg::*; #(
    parameter int BhtEntries = DEF_BHT_ENTRIES
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    // lookup side, fetch pc
    input  logic [XLEN-1:0] lookup_pc_i,
    output logic            hit_valid_o,
    output logic            hit_taken_o,
    // update side, resolved branches
    input  logic            update_valid_i,
    input  logic [XLEN-1:0] update_pc_i,
    input  logic            update_taken_i
);

    localparam int IdxW = $clog2(BhtEntries);

    logic [BhtEntries-1:0] valid_q;
    counter_t              cnt_q [BhtEntries];

    logic [IdxW-1:0] lookup_idx;
    logic [IdxW-1:0] update_idx;
    counter_t        cnt_base;
    counter_t        cnt_next;

    // word aligned pcs, drop the two low bits
    assign lookup_idx = lookup_pc_i[IdxW+1:2];
    assign update_idx = update_pc_i[IdxW+1:2];

    // ------------------------------------------------------------
    // read port
    // ------------------------------------------------------------
    assign hit_valid_o = valid_q[lookup_idx];
    assign hit_taken_o = cnt_q[lookup_idx][CNT_TAKEN_BIT];

    // ------------------------------------------------------------
    // counter update
    // ------------------------------------------------------------
    // a fresh entry steps from weak not taken
    assign cnt_base = valid_q[update_idx] ? cnt_q[update_idx] : CNT_WEAK_NT;

    always_comb begin
        cnt_next = cnt_base;
        if (update_taken_i && cnt_base != 2'b11) begin
            cnt_next = cnt_base + 2'b01;
        end else if (!update_taken_i && cnt_base != 2'b00) begin
            cnt_next = cnt_base - 2'b01;
        end
    end

    // valid bits come up cleared
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (update_valid_i) begin
            valid_q[update_idx] <= 1'b1;
        end
    end

    // counter storage, only meaningful behind a valid bit
    always_ff @(posedge clk_i) begin
        if (update_valid_i) begin
            cnt_q[update_idx] <= cnt_next;
        end
    end

endmodule

/* instr_scan.sv */
// combinational branch and JAL classifier with offset extraction
`timescale 1ns/1ps

module instr_scan import rv_isa_pkg::*; import fetch_pkg::*; (
    input  logic [INSTR_W-1:0] instr_i,
    output logic               is_branch_o,
    output logic               is_jal_o,
    output logic [XLEN-1:0]    offset_o
);

    logic [OPC_W-1:0]   opcode;
    logic [B_IMM_W-1:0] b_imm;
    logic [J_IMM_W-1:0] j_imm;

    assign opcode = instr_i[OPC_W-1:0];

    // ------------------------------------------------------------
    // immediate assembly
    // ------------------------------------------------------------
    // B-type: imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
    assign b_imm = {instr_i[SIGN_BIT], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};

    // J-type: imm[20|10:1|11|19:12] in 31:12
    assign j_imm = {instr_i[SIGN_BIT], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    // ------------------------------------------------------------
    // classification
    // ------------------------------------------------------------
    always_comb begin
        is_branch_o = 1'b0;
        is_jal_o    = 1'b0;
        offset_o    = '0;
        case (opcode)
            OPC_BRANCH: begin
                is_branch_o = 1'b1;
                offset_o    = {{(XLEN-B_IMM_W){b_imm[B_IMM_W-1]}}, b_imm};
            end
            OPC_JAL: begin
                is_jal_o = 1'b1;
                offset_o = {{(XLEN-J_IMM_W){j_imm[J_IMM_W-1]}}, j_imm};
            end
            // jalr, alu, load, store and the rest report no class,
            // register targets are left to the back end
            default: begin
                offset_o = '0;
            end
        endcase
    end

endmodule

/* fetch_pkg.sv */
// frontend widths, predictor counter encoding and default sizes
package fetch_pkg;

    // ------------------------------------------------------------
    // widths
    // ------------------------------------------------------------
    // address and pc width
    localparam int XLEN = 32;

    // ------------------------------------------------------------
    // prediction counter
    // ------------------------------------------------------------
    // two-bit saturating counter, 0 strongly not taken .. 3 strongly taken
    typedef logic [1:0] counter_t;

    // value an entry starts from on its first update
    localparam counter_t CNT_WEAK_NT = 2'b01;

    // upper half of the range predicts taken
    localparam int CNT_TAKEN_BIT = 1;

    // ------------------------------------------------------------
    // default sizes
    // ------------------------------------------------------------
    // power of two, 4 or more
    localparam int DEF_BHT_ENTRIES = 64;

    // 2 or more
    localparam int DEF_QUEUE_DEPTH = 4;

    // first fetch address after reset
    localparam logic [XLEN-1:0] DEF_BOOT_ADDR = 32'h0000_1000;

endpackage

/* rv_isa_pkg.sv */
// RV32I opcode values, instruction field positions and immediate widths
package rv_isa_pkg;

    // ------------------------------------------------------------
    // instruction word
    // ------------------------------------------------------------
    // one uncompressed instruction per fetched word
    localparam int INSTR_W = 32;
    // pc step from one instruction to the next
    localparam int ILEN_BYTES = 4;

    // ------------------------------------------------------------
    // field positions
    // ------------------------------------------------------------
    // major opcode sits in the low bits
    localparam int OPC_W = 7;
    // sign bit of every immediate
    localparam int SIGN_BIT = 31;

    // assembled immediate widths, bit 0 included
    localparam int B_IMM_W = 13;
    localparam int J_IMM_W = 21;

    // ------------------------------------------------------------
    // major opcodes
    // ------------------------------------------------------------
    localparam logic [OPC_W-1:0] OPC_BRANCH = 7'b1100011;
    localparam logic [OPC_W-1:0] OPC_JAL    = 7'b1101111;
    localparam logic [OPC_W-1:0] OPC_JALR   = 7'b1100111;

endpackage
